/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hazard_trap
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) rv_ctrl_defs.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hazard_trap_checker.sv */
//********************
// bound to hazard_trap_top, properties are sampled on the rising edge of clk_i
//********************
`timescale 1ns/100ps
`default_nettype none

`include "rv_ctrl_defs.svh"

module hazard_trap_checker (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input rv_ctrl_pkg::stage_ctrl_t stall_i,
    input rv_ctrl_pkg::stage_ctrl_t flush_i,
    input logic                     trap_taken_i,
    input logic                     mret_i,
    input logic                     redirect_valid_i,
    input logic [`RV_XLEN-1:0]      csr_rdata_i
);

    // a flushed stage loads a bubble and must not be held at the same time
    stall_flush_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) ((stall_i & flush_i) == '0)
    ) else $error("a stage is stalled and flushed in the same cycle");

    // every trap squashes at least the youngest instruction in fetch
    trap_flushes_fetch: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) trap_taken_i |-> flush_i.fetch
    ) else $error("a trap was taken without flushing fetch");

    redirect_matches_events: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) redirect_valid_i == (trap_taken_i | mret_i)
    ) else $error("the redirect strobe does not follow trap or mret");

    // inputs are idle during reset, so every output has to be zero
    quiet_in_reset: assert property (
        @(posedge clk_i) !rst_n_i |-> (stall_i == '0 && flush_i == '0 && !trap_taken_i
                                       && !redirect_valid_i && csr_rdata_i == '0)
    ) else $error("an output is active while reset is asserted");

endmodule

`default_nettype wire

/* hazard_trap_top.sv */
//********************
// outputs are combinational from this cycle's inputs, CSR updates land on the next edge
//********************
`timescale 1ns/100ps
`default_nettype none

`include "rv_ctrl_defs.svh"

module hazard_trap_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  rv_ctrl_pkg::stage_ctrl_t stall_req_i,
    input  logic                     mispredict_i,
    input  logic                     mret_i,
    input  rv_ctrl_pkg::exc_req_t    exc_req_i,
    input  rv_ctrl_pkg::irq_req_t    irq_i,
    input  logic [`RV_XLEN-1:0]      pc_fetch_i,
    input  logic [`RV_XLEN-1:0]      pc_decode_i,
    input  logic [`RV_XLEN-1:0]      pc_memory_i,
    input  logic [`RV_XLEN-1:0]      addr_memory_i,
    input  logic                     csr_we_i,
    input  logic [11:0]              csr_addr_i,
    input  logic [`RV_XLEN-1:0]      csr_wdata_i,
    output logic [`RV_XLEN-1:0]      csr_rdata_o,
    output rv_ctrl_pkg::stage_ctrl_t stall_o,
    output rv_ctrl_pkg::stage_ctrl_t flush_o,
    output logic                     trap_taken_o,
    output logic [`RV_XLEN-1:0]      trap_cause_o,
    output logic                     redirect_valid_o,
    output logic [`RV_XLEN-1:0]      redirect_pc_o
);

    import rv_ctrl_pkg::*;

    trap_info_t trap;
    logic [2:0] mie;
    logic       mstatus_mie;

    trap_arbiter arbiter_i (
        .exc_req_i     (exc_req_i),
        .irq_i         (irq_i),
        .mie_i         (mie),
        .global_ie_i   (mstatus_mie),
        .pc_fetch_i    (pc_fetch_i),
        .pc_decode_i   (pc_decode_i),
        .pc_memory_i   (pc_memory_i),
        .addr_memory_i (addr_memory_i),
        .trap_o        (trap)
    );

    pipeline_controller controller_i (
        .stall_req_i  (stall_req_i),
        .mispredict_i (mispredict_i),
        .mret_i       (mret_i),
        .trap_i       (trap),
        .stall_o      (stall_o),
        .flush_o      (flush_o)
    );

    machine_csr_file csr_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .trap_i           (trap),
        .mret_i           (mret_i),
        .irq_i            (irq_i),
        .csr_we_i         (csr_we_i),
        .csr_addr_i       (csr_addr_i),
        .csr_wdata_i      (csr_wdata_i),
        .csr_rdata_o      (csr_rdata_o),
        .mie_o            (mie),
        .mstatus_mie_o    (mstatus_mie),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    // the core watches these to see which instruction trapped
    assign trap_taken_o = trap.valid;
    assign trap_cause_o = trap.cause.raw;

endmodule

`default_nettype wire

/* machine_csr_file.sv */
//********************
// holds only the M-mode trap CSRs with a direct-mode mtvec and full-word writes
//********************
`timescale 1ns/100ps
`default_nettype none

`include "rv_ctrl_defs.svh"

module machine_csr_file (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  rv_ctrl_pkg::trap_info_t trap_i,
    input  logic                    mret_i,
    input  rv_ctrl_pkg::irq_req_t   irq_i,
    input  logic                    csr_we_i,
    input  logic [11:0]             csr_addr_i,
    input  logic [`RV_XLEN-1:0]     csr_wdata_i,
    output logic [`RV_XLEN-1:0]     csr_rdata_o,
    output logic [2:0]              mie_o,
    output logic                    mstatus_mie_o,
    output logic                    redirect_valid_o,
    output logic [`RV_XLEN-1:0]     redirect_pc_o
);

    import rv_ctrl_pkg::*;

    logic                mstatus_mie_q;
    logic                mstatus_mpie_q;
    logic [2:0]          mie_q;
    logic [`RV_XLEN-1:2] mtvec_q;
    logic [`RV_XLEN-1:0] mepc_q;
    mcause_u             mcause_q;
    logic [`RV_XLEN-1:0] mtval_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mtvec_q        <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mtval_q        <= '0;
        end else begin
            if (csr_we_i) begin
                case (csr_addr_i)
                    `CSR_MSTATUS: begin
                        mstatus_mie_q  <= csr_wdata_i[`MSTATUS_MIE_BIT];
                        mstatus_mpie_q <= csr_wdata_i[`MSTATUS_MPIE_BIT];
                    end
                    `CSR_MIE: begin
                        mie_q <= {csr_wdata_i[`IRQ_M_EXTERNAL],
                                  csr_wdata_i[`IRQ_M_TIMER],
                                  csr_wdata_i[`IRQ_M_SOFTWARE]};
                    end
                    // only direct mode exists, so the mode field is not stored
                    `CSR_MTVEC:  mtvec_q      <= csr_wdata_i[`RV_XLEN-1:2];
                    `CSR_MEPC:   mepc_q       <= csr_wdata_i;
                    `CSR_MCAUSE: mcause_q.raw <= csr_wdata_i;
                    `CSR_MTVAL:  mtval_q      <= csr_wdata_i;
                    default: begin
                    end
                endcase
            end

            // these assignments come last, so an event overrides a software
            // write to the same fields in this cycle
            if (trap_i.valid) begin
                mepc_q         <= trap_i.epc;
                mcause_q       <= trap_i.cause;
                mtval_q        <= trap_i.tval;
                mstatus_mpie_q <= mstatus_mie_q;
                mstatus_mie_q  <= 1'b0;
            end else if (mret_i) begin
                mstatus_mie_q  <= mstatus_mpie_q;
                mstatus_mpie_q <= 1'b1;
            end
        end
    end

    // unimplemented bits and unknown addresses read as zero
    always_comb begin
        csr_rdata_o = '0;
        case (csr_addr_i)
            `CSR_MSTATUS: begin
                csr_rdata_o[`MSTATUS_MIE_BIT]  = mstatus_mie_q;
                csr_rdata_o[`MSTATUS_MPIE_BIT] = mstatus_mpie_q;
            end
            `CSR_MIE: begin
                csr_rdata_o[`IRQ_M_EXTERNAL] = mie_q[2];
                csr_rdata_o[`IRQ_M_TIMER]    = mie_q[1];
                csr_rdata_o[`IRQ_M_SOFTWARE] = mie_q[0];
            end
            // mip follows the live interrupt lines and ignores writes
            `CSR_MIP: begin
                csr_rdata_o[`IRQ_M_EXTERNAL] = irq_i.external;
                csr_rdata_o[`IRQ_M_TIMER]    = irq_i.timer;
                csr_rdata_o[`IRQ_M_SOFTWARE] = irq_i.software;
            end
            `CSR_MTVEC:  csr_rdata_o = {mtvec_q, 2'b00};
            `CSR_MEPC:   csr_rdata_o = mepc_q;
            `CSR_MCAUSE: csr_rdata_o = mcause_q.raw;
            `CSR_MTVAL:  csr_rdata_o = mtval_q;
            default: begin
                csr_rdata_o = '0;
            end
        endcase
    end

    assign mie_o         = mie_q;
    assign mstatus_mie_o = mstatus_mie_q;

    // the trap handler target wins over the mret return address
    assign redirect_valid_o = trap_i.valid | mret_i;
    assign redirect_pc_o    = trap_i.valid ? {mtvec_q, 2'b00} : mepc_q;

endmodule

`default_nettype wire

/* pipeline_controller.sv */
//********************
// purely combinational, a trap takes priority over an mret in the same cycle
//********************
`timescale 1ns/100ps
`default_nettype none

module pipeline_controller (
    input  rv_ctrl_pkg::stage_ctrl_t stall_req_i,
    input  logic                     mispredict_i,
    input  logic                     mret_i,
    input  rv_ctrl_pkg::trap_info_t  trap_i,
    output rv_ctrl_pkg::stage_ctrl_t stall_o,
    output rv_ctrl_pkg::stage_ctrl_t flush_o
);

    import rv_ctrl_pkg::*;

    stage_ctrl_t stall_chain;
    stage_ctrl_t flush_vec;

    // a stalled stage holds its state, so every earlier stage has to hold as well
    // the deepest requesting stage decides the whole chain
    always_comb begin
        stall_chain = '0;
        if (stall_req_i.memory) begin
            stall_chain = 4'b1111;
        end else if (stall_req_i.execute) begin
            stall_chain = 4'b0111;
        end else if (stall_req_i.decode) begin
            stall_chain = 4'b0011;
        end else if (stall_req_i.fetch) begin
            stall_chain = 4'b0001;
        end
    end

    always_comb begin
        flush_vec = '0;

        // the raising stage and everything behind it are squashed
        if (trap_i.valid) begin
            case (trap_i.stage)
                TRAP_STAGE_FETCH: begin
                    flush_vec.fetch = 1'b1;
                end
                TRAP_STAGE_DECODE: begin
                    flush_vec.fetch  = 1'b1;
                    flush_vec.decode = 1'b1;
                end
                default: begin
                    flush_vec = 4'b1111;
                end
            endcase
        end

        // fetch already holds the corrected target when the branch resolves
        if (mispredict_i) begin
            flush_vec.decode  = 1'b1;
            flush_vec.execute = 1'b1;
        end

        if (mret_i && !trap_i.valid) begin
            flush_vec.decode  = 1'b1;
            flush_vec.execute = 1'b1;
        end
    end

    // a flushed stage loads a bubble, so holding it would be meaningless
    assign stall_o = stall_chain & ~flush_vec;
    assign flush_o = flush_vec;

endmodule

`default_nettype wire

/* rv_ctrl_defs.svh */
//********************
// widths, CSR addresses and cause codes for an M-mode only RV32 core
//********************
`ifndef RV_CTRL_DEFS_SVH
`define RV_CTRL_DEFS_SVH

// data and address width of the core
`define RV_XLEN 32

// machine-mode trap CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MTVAL   12'h343
`define CSR_MIP     12'h344

// bit positions of the two mstatus fields that are implemented
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7

// synchronous exception codes, written to mcause with the interrupt bit clear
`define EXC_INSTR_MISALIGNED 4'd0
`define EXC_ILLEGAL_INSTR    4'd2
`define EXC_BREAKPOINT       4'd3
`define EXC_LOAD_MISALIGNED  4'd4
`define EXC_STORE_MISALIGNED 4'd6
`define EXC_ECALL_M          4'd11

// interrupt codes, which are also the bit positions in mie and mip
`define IRQ_M_SOFTWARE 4'd3
`define IRQ_M_TIMER    4'd7
`define IRQ_M_EXTERNAL 4'd11

`endif

/* rv_ctrl_pkg.sv */
//********************
// shared types of the hazard and trap block, bit 0 of a stage vector is fetch
//********************
`default_nettype none

`include "rv_ctrl_defs.svh"

package rv_ctrl_pkg;

    // one bit per stage, used as a stall vector and as a flush vector
    // writeback never stalls and is never flushed so it has no bit
    typedef struct packed {
        logic memory;
        logic execute;
        logic decode;
        logic fetch;
    } stage_ctrl_t;

    // exception requests raised by the datapath stages
    typedef struct packed {
        logic load_addr_misaligned;
        logic store_addr_misaligned;
        logic breakpoint;
        logic env_call_m;
        logic illegal_instruction;
        logic instr_addr_misaligned;
    } exc_req_t;

    // machine interrupt lines, in the same order as the 3-bit mie vector
    typedef struct packed {
        logic external;
        logic timer;
        logic software;
    } irq_req_t;

    // stage that raised a trap, interrupts are taken at memory
    typedef enum logic [1:0] {
        TRAP_STAGE_FETCH  = 2'd0,
        TRAP_STAGE_DECODE = 2'd1,
        TRAP_STAGE_MEMORY = 2'd2
    } trap_stage_e;

    // mcause is stored as a raw word and built as interrupt bit plus code
    typedef union packed {
        logic [`RV_XLEN-1:0] raw;
        struct packed {
            logic        interrupt;
            logic [26:0] reserved;
            logic [3:0]  code;
        } fields;
    } mcause_u;

    typedef struct packed {
        logic                valid;
        mcause_u             cause;
        logic [`RV_XLEN-1:0] epc;
        logic [`RV_XLEN-1:0] tval;
        trap_stage_e         stage;
    } trap_info_t;

endpackage

`default_nettype wire

/* sources.f */
+incdir+.
rv_ctrl_pkg.sv
trap_arbiter.sv
pipeline_controller.sv
machine_csr_file.sv
hazard_trap_top.sv
hazard_trap_checker.sv
tb_hazard_trap.sv

/* tb_hazard_trap.sv */
//********************
// every table row takes a drive cycle and then a CSR readback cycle with quiet inputs
//********************
`timescale 1ns/100ps
`default_nettype none

`include "rv_ctrl_defs.svh"

module tb_hazard_trap;

    import rv_ctrl_pkg::*;

    // stimulus of one row with bit orders that follow the package structs
    typedef struct packed {
        logic [3:0]  stall_req;
        logic        mispredict;
        logic        mret;
        logic [5:0]  exc;
        logic [2:0]  irq;
        logic        csr_we;
        logic [11:0] csr_addr;
        logic [31:0] csr_wdata;
    } drive_t;

    // expected outputs of the drive cycle and the CSR value read one cycle later
    typedef struct packed {
        logic [3:0]  stall;
        logic [3:0]  flush;
        logic        trap;
        logic [31:0] cause;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic [11:0] rd_addr;
        logic [31:0] rd_data;
    } expect_t;

    localparam int          num_rows        = 23;
    localparam int          watchdog_cycles = 200;
    localparam logic [31:0] fetch_pc        = 32'h0000_0112;
    localparam logic [31:0] decode_pc       = 32'h0000_010c;
    localparam logic [31:0] mem_pc          = 32'h0000_0104;
    localparam logic [31:0] mem_addr        = 32'h0000_8003;
    localparam logic [31:0] handler_pc      = 32'h0000_0400;

    logic                clk_i;
    logic                rst_n_i;
    stage_ctrl_t         stall_req_i;
    logic                mispredict_i;
    logic                mret_i;
    exc_req_t            exc_req_i;
    irq_req_t            irq_i;
    logic [`RV_XLEN-1:0] pc_fetch_i;
    logic [`RV_XLEN-1:0] pc_decode_i;
    logic [`RV_XLEN-1:0] pc_memory_i;
    logic [`RV_XLEN-1:0] addr_memory_i;
    logic                csr_we_i;
    logic [11:0]         csr_addr_i;
    logic [`RV_XLEN-1:0] csr_wdata_i;
    logic [`RV_XLEN-1:0] csr_rdata_o;
    stage_ctrl_t         stall_o;
    stage_ctrl_t         flush_o;
    logic                trap_taken_o;
    logic [`RV_XLEN-1:0] trap_cause_o;
    logic                redirect_valid_o;
    logic [`RV_XLEN-1:0] redirect_pc_o;

    drive_t  drv [num_rows];
    expect_t exv [num_rows];
    int      row_idx;

    hazard_trap_top dut_i (.*);

    bind hazard_trap_top hazard_trap_checker checker_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall_o),
        .flush_i          (flush_o),
        .trap_taken_i     (trap_taken_o),
        .mret_i           (mret_i),
        .redirect_valid_i (redirect_valid_o),
        .csr_rdata_i      (csr_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic stop_with_failure(input string reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s in row %0d: got 0x%08h, expected 0x%08h",
                     name, row_idx, actual, expected);
            stop_with_failure("an output did not match its expected value");
        end
    endtask

    task automatic wait_cycles(input int count);
        for (int n = 0; n < count; n++) begin
            @(posedge clk_i);
        end
    endtask

    task automatic drive_inputs(input drive_t d);
        stall_req_i  = d.stall_req;
        mispredict_i = d.mispredict;
        mret_i       = d.mret;
        exc_req_i    = d.exc;
        irq_i        = d.irq;
        csr_we_i     = d.csr_we;
        csr_addr_i   = d.csr_addr;
        csr_wdata_i  = d.csr_wdata;
    endtask

    // all events stay idle and only the CSR read address is set
    task automatic drive_readback(input logic [11:0] addr);
        drive_inputs(drive_t'{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b0, addr, 32'h0});
    endtask

    task automatic check_outputs(input expect_t e);
        check_value("stall_o", {28'd0, stall_o}, {28'd0, e.stall});
        check_value("flush_o", {28'd0, flush_o}, {28'd0, e.flush});
        check_value("trap_taken_o", {31'd0, trap_taken_o}, {31'd0, e.trap});
        check_value("trap_cause_o", trap_cause_o, e.cause);
        check_value("redirect_valid_o", {31'd0, redirect_valid_o}, {31'd0, e.redirect});
        if (e.redirect) begin
            check_value("redirect_pc_o", redirect_pc_o, e.redirect_pc);
        end
    endtask

    task automatic fill_table();
        // stall chain from single and combined requests
        drv[0]  = '{4'b0001, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[0]  = '{4'b0001, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MSTATUS, 32'h0};
        drv[1]  = '{4'b0010, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[1]  = '{4'b0011, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MSTATUS, 32'h0};
        drv[2]  = '{4'b0100, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[2]  = '{4'b0111, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MSTATUS, 32'h0};
        drv[3]  = '{4'b1000, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[3]  = '{4'b1111, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MSTATUS, 32'h0};
        drv[4]  = '{4'b0101, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[4]  = '{4'b0111, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MSTATUS, 32'h0};
        // mispredict and mret flush decode and execute and mret returns to mepc
        drv[5]  = '{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b1, `CSR_MEPC, 32'h200};
        exv[5]  = '{4'b0000, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MEPC, 32'h200};
        drv[6]  = '{4'b0100, 1'b1, 1'b0, 6'b000000, 3'b000, 1'b1, `CSR_MTVEC, 32'h403};
        exv[6]  = '{4'b0001, 4'b0110, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MTVEC, handler_pc};
        drv[7]  = '{4'b1111, 1'b0, 1'b1, 6'b000000, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[7]  = '{4'b1001, 4'b0110, 1'b0, 32'h0, 1'b1, 32'h200, `CSR_MSTATUS, 32'h80};
        // exception ranking with several requests at once
        drv[8]  = '{4'b1111, 1'b0, 1'b0, 6'b110010, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[8]  = '{4'b0000, 4'b1111, 1'b1, 32'h4, 1'b1, handler_pc, `CSR_MEPC, mem_pc};
        drv[9]  = '{4'b0000, 1'b0, 1'b0, 6'b011000, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[9]  = '{4'b0000, 4'b1111, 1'b1, 32'h6, 1'b1, handler_pc, `CSR_MTVAL, mem_addr};
        drv[10] = '{4'b0111, 1'b0, 1'b0, 6'b001101, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[10] = '{4'b0100, 4'b0011, 1'b1, 32'h3, 1'b1, handler_pc, `CSR_MCAUSE, 32'h3};
        drv[11] = '{4'b0000, 1'b0, 1'b0, 6'b000110, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[11] = '{4'b0000, 4'b0011, 1'b1, 32'hb, 1'b1, handler_pc, `CSR_MTVAL, 32'h0};
        drv[12] = '{4'b0000, 1'b0, 1'b0, 6'b000011, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[12] = '{4'b0000, 4'b0011, 1'b1, 32'h2, 1'b1, handler_pc, `CSR_MEPC, decode_pc};
        drv[13] = '{4'b0000, 1'b0, 1'b0, 6'b000001, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[13] = '{4'b0000, 4'b0001, 1'b1, 32'h0, 1'b1, handler_pc, `CSR_MTVAL, fetch_pc};
        // interrupts stay masked until MIE and the matching mie bit are both set
        drv[14] = '{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b010, 1'b1, `CSR_MIE, 32'h80};
        exv[14] = '{4'b0000, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MIE, 32'h80};
        drv[15] = '{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b010, 1'b1, `CSR_MSTATUS, 32'h8};
        exv[15] = '{4'b0000, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MSTATUS, 32'h8};
        drv[16] = '{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b101, 1'b1, `CSR_MIE, 32'h888};
        exv[16] = '{4'b0000, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MIE, 32'h888};
        drv[17] = '{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b111, 1'b0, 12'h000, 32'h0};
        exv[17] = '{4'b0000, 4'b1111, 1'b1, 32'h8000_000b, 1'b1, handler_pc,
                    `CSR_MSTATUS, 32'h80};
        drv[18] = '{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b1, `CSR_MSTATUS, 32'h8};
        exv[18] = '{4'b0000, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MTVAL, 32'h0};
        drv[19] = '{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b011, 1'b0, 12'h000, 32'h0};
        exv[19] = '{4'b0000, 4'b1111, 1'b1, 32'h8000_0003, 1'b1, handler_pc,
                    `CSR_MCAUSE, 32'h8000_0003};
        // a trap beats mret and a software write to mepc and a later mret restores MIE
        drv[20] = '{4'b0000, 1'b0, 1'b0, 6'b000000, 3'b000, 1'b1, `CSR_MSTATUS, 32'h88};
        exv[20] = '{4'b0000, 4'b0000, 1'b0, 32'h0, 1'b0, 32'h0, `CSR_MSTATUS, 32'h88};
        drv[21] = '{4'b0000, 1'b0, 1'b1, 6'b000010, 3'b010, 1'b1, `CSR_MEPC, 32'hbad0};
        exv[21] = '{4'b0000, 4'b0011, 1'b1, 32'h2, 1'b1, handler_pc, `CSR_MEPC, decode_pc};
        drv[22] = '{4'b0000, 1'b0, 1'b1, 6'b000000, 3'b000, 1'b0, 12'h000, 32'h0};
        exv[22] = '{4'b0000, 4'b0110, 1'b0, 32'h0, 1'b1, decode_pc, `CSR_MSTATUS, 32'h88};
    endtask

    initial begin
        row_idx       = 0;
        rst_n_i       = 1'b0;
        pc_fetch_i    = fetch_pc;
        pc_decode_i   = decode_pc;
        pc_memory_i   = mem_pc;
        addr_memory_i = mem_addr;
        drive_readback(12'h000);
        fill_table();
        wait_cycles(4);
        #1 rst_n_i = 1'b1;
        for (row_idx = 0; row_idx < num_rows; row_idx++) begin
            wait_cycles(1);
            #1 drive_inputs(drv[row_idx]);
            #2 check_outputs(exv[row_idx]);
            // the CSR updates of the row are visible after this edge
            wait_cycles(1);
            #1 drive_readback(exv[row_idx].rd_addr);
            #2 check_value("csr_rdata_o", csr_rdata_o, exv[row_idx].rd_data);
            check_value("flush_o", {28'd0, flush_o}, 32'h0);
            check_value("redirect_valid_o", {31'd0, redirect_valid_o}, 32'h0);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        for (int cycle = 0; cycle < watchdog_cycles; cycle++) begin
            @(posedge clk_i);
        end
        stop_with_failure("the run did not finish before the watchdog limit");
    end

endmodule

`default_nettype wire

/* trap_arbiter.sv */
//********************
// one trap per cycle, interrupts only when no exception is present
//********************
`timescale 1ns/100ps
`default_nettype none

`include "rv_ctrl_defs.svh"

module trap_arbiter (
    input  rv_ctrl_pkg::exc_req_t   exc_req_i,
    input  rv_ctrl_pkg::irq_req_t   irq_i,
    input  logic [2:0]              mie_i,
    input  logic                    global_ie_i,
    input  logic [`RV_XLEN-1:0]     pc_fetch_i,
    input  logic [`RV_XLEN-1:0]     pc_decode_i,
    input  logic [`RV_XLEN-1:0]     pc_memory_i,
    input  logic [`RV_XLEN-1:0]     addr_memory_i,
    output rv_ctrl_pkg::trap_info_t trap_o
);

    import rv_ctrl_pkg::*;

    irq_req_t irq_active;
    logic     exc_any;
    logic     irq_take;

    // an interrupt line counts only while its enable bit in mie is set
    assign irq_active = irq_i & mie_i;
    assign exc_any    = |exc_req_i;
    assign irq_take   = !exc_any && global_ie_i && (|irq_active);

    always_comb begin
        trap_o       = '0;
        trap_o.stage = TRAP_STAGE_MEMORY;

        // memory-stage faults belong to the oldest instruction and rank first
        if (exc_req_i.load_addr_misaligned) begin
            trap_o.valid             = 1'b1;
            trap_o.cause.fields.code = `EXC_LOAD_MISALIGNED;
            trap_o.epc               = pc_memory_i;
            trap_o.tval              = addr_memory_i;
            trap_o.stage             = TRAP_STAGE_MEMORY;
        end else if (exc_req_i.store_addr_misaligned) begin
            trap_o.valid             = 1'b1;
            trap_o.cause.fields.code = `EXC_STORE_MISALIGNED;
            trap_o.epc               = pc_memory_i;
            trap_o.tval              = addr_memory_i;
            trap_o.stage             = TRAP_STAGE_MEMORY;
        end else if (exc_req_i.breakpoint) begin
            trap_o.valid             = 1'b1;
            trap_o.cause.fields.code = `EXC_BREAKPOINT;
            trap_o.epc               = pc_decode_i;
            trap_o.stage             = TRAP_STAGE_DECODE;
        end else if (exc_req_i.env_call_m) begin
            trap_o.valid             = 1'b1;
            trap_o.cause.fields.code = `EXC_ECALL_M;
            trap_o.epc               = pc_decode_i;
            trap_o.stage             = TRAP_STAGE_DECODE;
        end else if (exc_req_i.illegal_instruction) begin
            trap_o.valid             = 1'b1;
            trap_o.cause.fields.code = `EXC_ILLEGAL_INSTR;
            trap_o.epc               = pc_decode_i;
            trap_o.stage             = TRAP_STAGE_DECODE;
        end else if (exc_req_i.instr_addr_misaligned) begin
            // the faulting address is the fetch pc itself
            trap_o.valid             = 1'b1;
            trap_o.cause.fields.code = `EXC_INSTR_MISALIGNED;
            trap_o.epc               = pc_fetch_i;
            trap_o.tval              = pc_fetch_i;
            trap_o.stage             = TRAP_STAGE_FETCH;
        end else if (irq_take) begin
            // interrupts are taken on the instruction in memory, which has not committed yet
            trap_o.valid                  = 1'b1;
            trap_o.cause.fields.interrupt = 1'b1;
            trap_o.epc                    = pc_memory_i;
            trap_o.stage                  = TRAP_STAGE_MEMORY;
            if (irq_active.external) begin
                trap_o.cause.fields.code = `IRQ_M_EXTERNAL;
            end else if (irq_active.software) begin
                trap_o.cause.fields.code = `IRQ_M_SOFTWARE;
            end else begin
                trap_o.cause.fields.code = `IRQ_M_TIMER;
            end
        end
    end

endmodule

`default_nettype wire
